// File: wrr_mux.f
verilog/wrr_pkg.sv
verilog/pri_rr_arb.sv
verilog/sat_counter.sv
verilog/weighted_rr_arb.sv
verilog/out_stage.sv
verilog/wrr_mux.sv
test/wrr_mux_assert.sv
test/wrr_mux_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the wrr_mux testbench with Verilator and runs it once

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG_FILE=sim.log
SIM_BIN=wrr_mux_sim

verilator --binary --timing --assert --timescale 1ns/1ps \
  -Mdir "$OBJ_DIR" --top-module wrr_mux_tb -o "$SIM_BIN" -f wrr_mux.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Concurrent assertions keep running after a failure so the testbench can end the run
"./$OBJ_DIR/$SIM_BIN" +verilator+error+limit+100 > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^TB PASSED$" "$LOG_FILE"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, no pass line in $LOG_FILE"
  exit 1
fi

// File: test/wrr_mux_tb.sv
`timescale 1ns/1ps
`default_nettype none

module wrr_mux_tb;
  import wrr_pkg::*;

  localparam int NUM_PORTS  = DEF_NUM_PORTS;
  localparam int MAX_WEIGHT = DEF_MAX_WEIGHT;
  localparam int MAX_ACCUM  = DEF_MAX_WEIGHT;
  localparam int PAYLOAD_W  = DEF_PAYLOAD_W;
  localparam int WEIGHT_W   = weight_w(MAX_WEIGHT);
  localparam int IDX_W      = idx_w(NUM_PORTS);
  localparam int SEQ_W      = PAYLOAD_W - IDX_W;
  localparam int PERIOD     = 40;
  localparam int RST_CYCLES = 16;
  // Most items the last port may watch go by before it is served
  localparam int STARVE_MAX = (MAX_ACCUM + 1) * (NUM_PORTS - 1);

  // ------------------------------
  // Phases and run length
  // ------------------------------
  localparam int MODE_RANDOM = 0;
  localparam int MODE_ALL    = 1;
  localparam int MODE_SUBSET = 2;
  localparam int MODE_BACKP  = 3;
  localparam int MODE_STARVE = 4;
  localparam int RAND_CYCLES   = 300;
  localparam int ALL_CYCLES    = 140;
  localparam int SUB_CYCLES    = 100;
  localparam int BP_CYCLES     = 200;
  localparam int BP_HOLD       = 30;
  localparam int STARVE_CYCLES = 400;
  localparam int TOTAL_CYCLES  = RAND_CYCLES + ALL_CYCLES + SUB_CYCLES + BP_CYCLES
                                 + STARVE_CYCLES + 5 * (RST_CYCLES + 2);
  localparam int WATCHDOG_NS   = (TOTAL_CYCLES + 100) * PERIOD;

  logic                                clk;
  logic                                arst_n;
  logic [NUM_PORTS-1:0]                in_valid;
  logic [NUM_PORTS-1:0]                in_ready;
  logic [NUM_PORTS-1:0][PAYLOAD_W-1:0] in_data;
  logic [NUM_PORTS-1:0][WEIGHT_W-1:0]  weight;
  logic                                out_valid;
  logic                                out_ready;
  logic [PAYLOAD_W-1:0]                out_data;
  logic [IDX_W-1:0]                    out_src;

  // Scoreboard state
  logic [31:0]          rng;
  int unsigned          tx_seq [NUM_PORTS];
  int unsigned          rx_seq [NUM_PORTS];
  int                   win_cnt [NUM_PORTS];
  int                   win_items;
  int                   win_len;
  logic [NUM_PORTS-1:0] win_mask;
  logic                 win_en;
  int                   starve_cnt;
  logic                 lat_pend;
  logic [PAYLOAD_W-1:0] lat_data;
  logic [NUM_PORTS-1:0] in_fire;
  logic                 out_fire;

  wrr_mux #(
    .NUM_PORTS (NUM_PORTS),
    .MAX_WEIGHT(MAX_WEIGHT),
    .MAX_ACCUM (MAX_ACCUM),
    .PAYLOAD_W (PAYLOAD_W)
  ) uut (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_data  (in_data),
    .weight   (weight),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_data (out_data),
    .out_src  (out_src)
  );

  bind wrr_mux wrr_mux_assert #(
    .NUM_PORTS(NUM_PORTS),
    .PAYLOAD_W(PAYLOAD_W)
  ) u_wrr_mux_assert (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_data (out_data),
    .out_src  (out_src)
  );

  always #(PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Items in one refill round, that is the sum of the active weights
  function automatic int window_length(input logic [NUM_PORTS-1:0] mask);
    int total;
    total = 0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (mask[i]) begin
        total += int'(weight[i]);
      end
    end
    return total;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("FAILED %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    $display("TB FAILED");
    $fatal(1, "Mismatch on %s", name);
  endtask

  task automatic report_problem(input string what);
    $display("Error at %0t: %s", $time, what);
    $display("TB FAILED");
    $fatal(1, "%s", what);
  endtask

  // ------------------------------
  // Reset and source model
  // ------------------------------
  // Clears the DUT and the scoreboard so each phase starts from empty credit
  task automatic apply_reset();
    arst_n    = 1'b0;
    in_valid  = '0;
    out_ready = 1'b0;
    in_fire   = '0;
    lat_pend  = 1'b0;
    win_items = 0;
    starve_cnt = 0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      tx_seq[i]  = 0;
      rx_seq[i]  = 0;
      win_cnt[i] = 0;
    end
    repeat (RST_CYCLES) @(posedge clk);
    #2;
    arst_n = 1'b1;
    @(negedge clk);
    assert (!out_valid) else report_mismatch("out_valid", out_valid, 0);
    assert (in_ready == '0) else report_mismatch("in_ready", in_ready, 0);
    @(posedge clk);
    #2;
  endtask

  // A source holds its item until it transfers, then offers the next one
  task automatic drive_inputs(input int mode, input int cyc);
    logic [NUM_PORTS-1:0] want;
    rng = xorshift32(rng);
    case (mode)
      MODE_ALL:    want = '1;
      MODE_SUBSET: want = win_mask;
      default:     want = rng[NUM_PORTS-1:0];
    endcase
    if (mode == MODE_STARVE) begin
      want[NUM_PORTS-1] = 1'b1;
    end
    if (mode == MODE_ALL || mode == MODE_SUBSET) begin
      out_ready = 1'b1;
    end else if (mode == MODE_BACKP && cyc < BP_HOLD) begin
      out_ready = 1'b0;
    end else begin
      out_ready = |rng[10:9];
    end
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (in_fire[i]) begin
        tx_seq[i]++;
      end
      if (!in_valid[i] || in_fire[i]) begin
        in_valid[i] = want[i];
        in_data[i]  = {IDX_W'(i), SEQ_W'(tx_seq[i])};
      end
    end
  endtask

  // ------------------------------
  // Checks at the falling edge
  // ------------------------------
  task automatic check_outputs(input int mode);
    logic [IDX_W-1:0] src;
    logic [SEQ_W-1:0] seq;
    int               exp_cnt;
    in_fire  = in_valid & in_ready;
    out_fire = out_valid & out_ready;
    // A full stream with the sink always ready moves one item every cycle
    if (mode == MODE_ALL || mode == MODE_SUBSET) begin
      assert (|in_fire)
        else report_problem("No item accepted while the sources and the sink were ready");
    end
    // One cycle of latency from accept to out_valid
    if (lat_pend) begin
      assert (out_valid) else report_problem("No out_valid one cycle after an accept");
      assert (out_data == lat_data) else report_mismatch("out_data", out_data, lat_data);
    end
    lat_pend = |in_fire;
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (in_fire[i]) begin
        lat_data = in_data[i];
      end
    end
    if (out_valid && !out_ready) begin
      assert (in_ready == '0) else report_mismatch("in_ready", in_ready, 0);
    end
    if (out_fire) begin
      src = out_data[PAYLOAD_W-1 -: IDX_W];
      seq = out_data[SEQ_W-1:0];
      assert (out_src == src) else report_mismatch("out_src", out_src, src);
      assert (seq == SEQ_W'(rx_seq[src]))
        else report_mismatch("out_data sequence", seq, SEQ_W'(rx_seq[src]));
      rx_seq[src]++;
      if (win_en) begin
        win_cnt[src]++;
        win_items++;
        // A full round must match the weights of the active ports exactly
        if (win_items == win_len) begin
          for (int i = 0; i < NUM_PORTS; i++) begin
            exp_cnt = win_mask[i] ? int'(weight[i]) : 0;
            assert (win_cnt[i] == exp_cnt)
              else report_mismatch($sformatf("out_src count of port %0d", i),
                                   win_cnt[i], exp_cnt);
            win_cnt[i] = 0;
          end
          win_items = 0;
        end
      end
    end
    // Accepted items that pass the last port by while it waits
    if (mode == MODE_STARVE && (|in_fire)) begin
      if (in_fire[NUM_PORTS-1]) begin
        starve_cnt = 0;
      end else begin
        starve_cnt++;
        assert (starve_cnt <= STARVE_MAX)
          else report_problem($sformatf("Port %0d waited past %0d accepted items",
                                        NUM_PORTS - 1, STARVE_MAX));
      end
    end
  endtask

  task automatic run_phase(input int mode, input int cycles, input logic [NUM_PORTS-1:0] mask);
    apply_reset();
    win_mask = mask;
    win_len  = window_length(mask);
    win_en   = (mode == MODE_ALL) || (mode == MODE_SUBSET);
    drive_inputs(mode, 0);
    for (int cyc = 0; cyc < cycles; cyc++) begin
      @(negedge clk);
      check_outputs(mode);
      @(posedge clk);
      #2;
      drive_inputs(mode, cyc + 1);
    end
  endtask

  // A failed property in the bound checker ends the run here
  always @(negedge clk) begin
    if (uut.u_wrr_mux_assert.any_fail) begin
      report_problem("A concurrent assertion on wrr_mux failed");
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("TB FAILED");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    clk       = 1'b0;
    arst_n    = 1'b1;
    in_valid  = '0;
    in_data   = '0;
    out_ready = 1'b0;
    weight[0] = WEIGHT_W'(3);
    weight[1] = WEIGHT_W'(1);
    weight[2] = WEIGHT_W'(2);
    weight[3] = WEIGHT_W'(1);
    rng       = 32'h9a8c;
    win_en    = 1'b0;
    // The first reset edge comes once every process is running
    #1;
    run_phase(MODE_RANDOM, RAND_CYCLES, '1);
    run_phase(MODE_ALL, ALL_CYCLES, '1);
    // Only ports 0 and 2 request
    run_phase(MODE_SUBSET, SUB_CYCLES, 4'b0101);
    run_phase(MODE_BACKP, BP_CYCLES, '1);
    run_phase(MODE_STARVE, STARVE_CYCLES, '1);
    @(negedge clk);
    if (uut.u_wrr_mux_assert.any_fail) begin
      $display("TB FAILED");
      $fatal(1, "Assertion failure at the end of the run");
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: test/wrr_mux_assert.sv
`timescale 1ns/1ps
`default_nettype none

// Protocol properties of the multiplexer, bound into wrr_mux
module wrr_mux_assert #(
  parameter int NUM_PORTS = wrr_pkg::DEF_NUM_PORTS,
  parameter int PAYLOAD_W = wrr_pkg::DEF_PAYLOAD_W
) (
  input logic                                 clk,
  input logic                                 arst_n,
  input logic [NUM_PORTS-1:0]                 in_valid,
  input logic [NUM_PORTS-1:0]                 in_ready,
  input logic                                 out_valid,
  input logic                                 out_ready,
  input logic [PAYLOAD_W-1:0]                 out_data,
  input logic [wrr_pkg::idx_w(NUM_PORTS)-1:0] out_src
);

  // Each flag stays set once its property has failed
  logic fail_onehot = 1'b0;
  logic fail_no_req = 1'b0;
  logic fail_hold   = 1'b0;
  logic fail_reset  = 1'b0;
  logic any_fail;

  assign any_fail = fail_onehot | fail_no_req | fail_hold | fail_reset;

  // ------------------------------
  // Input side
  // ------------------------------
  // At most one source is granted per cycle
  onehot_ready: assert property (@(posedge clk) disable iff (!arst_n)
    $onehot0(in_ready))
    else begin
      fail_onehot = 1'b1;
      $error("in_ready has more than one bit set");
    end

  // A grant only goes to a source that asks for one
  ready_needs_valid: assert property (@(posedge clk) disable iff (!arst_n)
    (in_ready & ~in_valid) == '0)
    else begin
      fail_no_req = 1'b1;
      $error("in_ready is high on a port without in_valid");
    end

  // ------------------------------
  // Output side
  // ------------------------------
  // A stalled item keeps its payload and its source tag
  hold_under_stall: assert property (@(posedge clk) disable iff (!arst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data) && $stable(out_src)))
    else begin
      fail_hold = 1'b1;
      $error("Output item changed while out_ready was low");
    end

  // Nothing is offered during reset or on the first edge after it
  quiet_after_reset: assert property (@(posedge clk)
    (!arst_n || $rose(arst_n)) |-> !out_valid)
    else begin
      fail_reset = 1'b1;
      $error("out_valid is high during or right after reset");
    end

endmodule

`default_nettype wire

// File: verilog/wrr_mux.sv
`timescale 1ns/1ps
`default_nettype none

// Weighted round-robin stream multiplexer
// Arbitration is combinational and the winner lands in a one-deep output register
module wrr_mux #(
  parameter int NUM_PORTS  = wrr_pkg::DEF_NUM_PORTS,
  parameter int MAX_WEIGHT = wrr_pkg::DEF_MAX_WEIGHT,
  parameter int MAX_ACCUM  = wrr_pkg::DEF_MAX_WEIGHT,
  parameter int PAYLOAD_W  = wrr_pkg::DEF_PAYLOAD_W
) (
  input  logic                                                  clk,
  input  logic                                                  arst_n,
  input  logic [NUM_PORTS-1:0]                                  in_valid,
  output logic [NUM_PORTS-1:0]                                  in_ready,
  input  logic [NUM_PORTS-1:0][PAYLOAD_W-1:0]                   in_data,
  input  logic [NUM_PORTS-1:0][wrr_pkg::weight_w(MAX_WEIGHT)-1:0] weight,
  output logic                                                  out_valid,
  input  logic                                                  out_ready,
  output logic [PAYLOAD_W-1:0]                                  out_data,
  output logic [wrr_pkg::idx_w(NUM_PORTS)-1:0]                  out_src
);
  import wrr_pkg::*;

  localparam int IDX_W = idx_w(NUM_PORTS);

  logic                 accept;
  logic                 stage_empty;
  logic [NUM_PORTS-1:0] grant;
  logic [IDX_W-1:0]     grant_idx;
  logic [PAYLOAD_W-1:0] grant_data;

  // The stage can take an item when it is empty or is being drained
  assign accept   = stage_empty || out_ready;
  // Under back-pressure no source sees ready
  assign in_ready = accept ? grant : '0;

  weighted_rr_arb #(
    .NUM_PORTS (NUM_PORTS),
    .MAX_WEIGHT(MAX_WEIGHT),
    .MAX_ACCUM (MAX_ACCUM)
  ) u_weighted_rr_arb (
    .clk    (clk),
    .arst_n (arst_n),
    .update (accept),
    .request(in_valid),
    .weight (weight),
    .grant  (grant)
  );

  // ------------------------------
  // Grant encode and payload select
  // ------------------------------
  // Grant is one-hot, so OR-ing the selected terms gives the winner
  always_comb begin
    grant_idx  = '0;
    grant_data = '0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (grant[i]) begin
        grant_idx  = grant_idx | IDX_W'(i);
        grant_data = grant_data | in_data[i];
      end
    end
  end

  out_stage #(
    .PAYLOAD_W(PAYLOAD_W),
    .NUM_PORTS(NUM_PORTS)
  ) u_out_stage (
    .clk      (clk),
    .arst_n   (arst_n),
    .load     (accept && (|in_valid)),
    .load_data(grant_data),
    .load_src (grant_idx),
    .out_ready(out_ready),
    .out_valid(out_valid),
    .out_data (out_data),
    .out_src  (out_src),
    .empty    (stage_empty)
  );

endmodule

`default_nettype wire

// File: verilog/out_stage.sv
`timescale 1ns/1ps
`default_nettype none

// One-entry output register with a valid/ready handshake
// The item is tagged with the index of the port it came from
module out_stage #(
  parameter int PAYLOAD_W = wrr_pkg::DEF_PAYLOAD_W,
  parameter int NUM_PORTS = wrr_pkg::DEF_NUM_PORTS
) (
  input  logic                                 clk,
  input  logic                                 arst_n,
  input  logic                                 load,
  input  logic [PAYLOAD_W-1:0]                 load_data,
  input  logic [wrr_pkg::idx_w(NUM_PORTS)-1:0] load_src,
  input  logic                                 out_ready,
  output logic                                 out_valid,
  output logic [PAYLOAD_W-1:0]                 out_data,
  output logic [wrr_pkg::idx_w(NUM_PORTS)-1:0] out_src,
  output logic                                 empty
);

  // ------------------------------
  // Occupancy
  // ------------------------------
  // The parent only loads when the entry is empty or leaving this cycle,
  // so a load always wins over a drain
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else if (load) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // ------------------------------
  // Payload and source tag
  // ------------------------------
  always_ff @(posedge clk) begin
    if (load) begin
      out_data <= load_data;
      out_src  <= load_src;
    end
  end

  // Feeds the accept term in the parent
  assign empty = !out_valid;

endmodule

`default_nettype wire

// File: verilog/weighted_rr_arb.sv
`timescale 1ns/1ps
`default_nettype none

// Weighted round-robin arbiter
// A port with credit left in its accumulator outranks ports without
// When no requester has credit, every accumulator is refilled by its weight
module weighted_rr_arb #(
  parameter int NUM_PORTS  = wrr_pkg::DEF_NUM_PORTS,
  parameter int MAX_WEIGHT = wrr_pkg::DEF_MAX_WEIGHT,
  parameter int MAX_ACCUM  = wrr_pkg::DEF_MAX_WEIGHT
) (
  input  logic                                                  clk,
  input  logic                                                  arst_n,
  input  logic                                                  update,
  input  logic [NUM_PORTS-1:0]                                  request,
  input  logic [NUM_PORTS-1:0][wrr_pkg::weight_w(MAX_WEIGHT)-1:0] weight,
  output logic [NUM_PORTS-1:0]                                  grant
);
  import wrr_pkg::*;

  localparam int ACC_W = weight_w(MAX_ACCUM);

  // ------------------------------
  // Parameter checks
  // ------------------------------
  if (NUM_PORTS < 2) begin : gen_chk_ports
    $error("weighted_rr_arb needs NUM_PORTS of at least 2");
  end
  if (MAX_WEIGHT < 1) begin : gen_chk_weight
    $error("weighted_rr_arb needs MAX_WEIGHT of at least 1");
  end
  if (MAX_ACCUM < MAX_WEIGHT) begin : gen_chk_accum
    $error("weighted_rr_arb needs MAX_ACCUM of at least MAX_WEIGHT");
  end

  logic [NUM_PORTS-1:0]            high_pri;
  logic [NUM_PORTS-1:0][ACC_W-1:0] accum;
  logic                            any_hi_req;
  logic                            refill;
  logic [NUM_PORTS-1:0]            decr;

  // Refill only once every active requester has spent its credit
  assign any_hi_req = |(request & high_pri);
  assign refill     = update && (|request) && !any_hi_req;
  // The winner pays one unit of credit when the grant is taken
  assign decr       = update ? grant : '0;

  pri_rr_arb #(
    .NUM_PORTS(NUM_PORTS)
  ) u_pri_rr_arb (
    .clk     (clk),
    .arst_n  (arst_n),
    .update  (update),
    .request (request),
    .high_pri(high_pri),
    .grant   (grant)
  );

  // ------------------------------
  // Per-port credit
  // ------------------------------
  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_accum
    sat_counter #(
      .MAX_VALUE(MAX_ACCUM),
      .MAX_STEP (MAX_WEIGHT)
    ) u_sat_counter (
      .clk    (clk),
      .arst_n (arst_n),
      .incr_en(refill),
      .incr   (weight[i]),
      .decr_en(decr[i]),
      .value  (accum[i])
    );

    // Any credit left lifts the port into the high level
    assign high_pri[i] = |accum[i];
  end

endmodule

`default_nettype wire

// File: verilog/sat_counter.sv
`timescale 1ns/1ps
`default_nettype none

// Saturating accumulator that adds a step and takes away one in a single update
module sat_counter #(
  parameter int MAX_VALUE = wrr_pkg::DEF_MAX_WEIGHT,
  parameter int MAX_STEP  = wrr_pkg::DEF_MAX_WEIGHT
) (
  input  logic                                   clk,
  input  logic                                   arst_n,
  input  logic                                   incr_en,
  input  logic [wrr_pkg::weight_w(MAX_STEP)-1:0]  incr,
  input  logic                                   decr_en,
  output logic [wrr_pkg::weight_w(MAX_VALUE)-1:0] value
);
  import wrr_pkg::*;

  localparam int VAL_W  = weight_w(MAX_VALUE);
  localparam int STEP_W = weight_w(MAX_STEP);
  // Sign bit plus one carry bit above the wider operand
  localparam int SUM_W  = ((VAL_W > STEP_W) ? VAL_W : STEP_W) + 2;

  logic signed [SUM_W-1:0] sum;
  logic        [VAL_W-1:0] value_d;

  always_comb begin
    sum = $signed({{(SUM_W - VAL_W){1'b0}}, value});
    if (incr_en) begin
      sum = sum + $signed({{(SUM_W - STEP_W){1'b0}}, incr});
    end
    if (decr_en) begin
      sum = sum - SUM_W'(1);
    end
    // Clamp into 0 .. MAX_VALUE
    if (sum < 0) begin
      value_d = '0;
    end else if (sum > SUM_W'(MAX_VALUE)) begin
      value_d = VAL_W'(MAX_VALUE);
    end else begin
      value_d = VAL_W'(sum);
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      value <= '0;
    end else begin
      value <= value_d;
    end
  end

endmodule

`default_nettype wire

// File: verilog/pri_rr_arb.sv
`timescale 1ns/1ps
`default_nettype none

// Two-level round-robin arbiter
// High-priority requests win over plain ones and both levels scan from the same pointer
module pri_rr_arb #(
  parameter int NUM_PORTS = wrr_pkg::DEF_NUM_PORTS
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 update,
  input  logic [NUM_PORTS-1:0] request,
  input  logic [NUM_PORTS-1:0] high_pri,
  output logic [NUM_PORTS-1:0] grant
);
  import wrr_pkg::*;

  localparam int IDX_W = idx_w(NUM_PORTS);

  // Port that is looked at first in the next arbitration
  logic [IDX_W-1:0] ptr;
  logic [IDX_W-1:0] win_idx;
  logic             win_any;

  // ------------------------------
  // Combinational selection
  // ------------------------------
  always_comb begin
    int               idx;
    logic             hi_found;
    logic             lo_found;
    logic [IDX_W-1:0] hi_idx;
    logic [IDX_W-1:0] lo_idx;
    hi_found = 1'b0;
    lo_found = 1'b0;
    hi_idx   = '0;
    lo_idx   = '0;
    // Walk the ports in round-robin order starting at the pointer
    for (int off = 0; off < NUM_PORTS; off++) begin
      idx = int'(ptr) + off;
      if (idx >= NUM_PORTS) begin
        idx = idx - NUM_PORTS;
      end
      // First high-priority requester in the walk
      if (request[idx] && high_pri[idx] && !hi_found) begin
        hi_found = 1'b1;
        hi_idx   = IDX_W'(idx);
      end
      // First requester of any priority, used as the fallback
      if (request[idx] && !lo_found) begin
        lo_found = 1'b1;
        lo_idx   = IDX_W'(idx);
      end
    end
    win_any = hi_found | lo_found;
    win_idx = hi_found ? hi_idx : lo_idx;
    grant   = '0;
    if (win_any) begin
      grant[win_idx] = 1'b1;
    end
  end

  // ------------------------------
  // Round-robin pointer
  // ------------------------------
  // The pointer moves one past the winner, and only when the grant is taken
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ptr <= '0;
    end else if (update && win_any) begin
      if (win_idx == IDX_W'(NUM_PORTS - 1)) begin
        ptr <= '0;
      end else begin
        ptr <= win_idx + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/wrr_pkg.sv
`default_nettype none

package wrr_pkg;

  // Defaults used by the top level when it is not overridden
  localparam int DEF_NUM_PORTS  = 4;
  localparam int DEF_MAX_WEIGHT = 3;
  localparam int DEF_PAYLOAD_W  = 16;

  // Bits needed to hold any value from 0 up to max_value
  function automatic int weight_w(input int max_value);
    if (max_value < 1) begin
      return 1;
    end
    return $clog2(max_value + 1);
  endfunction

  // Bits needed for a port index, never less than one
  function automatic int idx_w(input int num_ports);
    if (num_ports <= 2) begin
      return 1;
    end
    return $clog2(num_ports);
  endfunction

endpackage

`default_nettype wire
